/* design/ps2_cfg.svh */
`ifndef PS2_CFG_SVH
`define PS2_CFG_SVH

// System clocks without a bit strobe before a partial frame is dropped
`define PS2_IDLE_TIMEOUT 2000

// Scan code set 2 prefix bytes
`define PS2_EXT_PREFIX   8'hE0
`define PS2_BREAK_PREFIX 8'hF0

`endif

/* design/ps2_frame_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ps2_cfg.svh"

module ps2_frame_ctrl
    import ps2_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        bit_strobe,
    input  wire        bit_value,
    output logic       frame_valid,
    output ps2_frame_t frame
);

    localparam int IDLE_W = $clog2(`PS2_IDLE_TIMEOUT);

    frame_state_t      state;
    logic [2:0]        bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    scan_code_t        shift_reg;
    logic              parity_acc;  // Running XOR of data and parity bits

    // Control path
    always_ff @(posedge clk) begin
        frame_valid <= 1'b0;
        if (!rst_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            idle_cnt <= '0;
        end else if (bit_strobe) begin
            idle_cnt <= '0;
            case (state)
                st_idle: begin
                    if (!bit_value) begin  // Start bit
                        state   <= st_data;
                        bit_cnt <= '0;
                    end
                end
                st_data: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= st_parity;
                    end
                end
                st_parity: state <= st_stop;
                st_stop: begin
                    state       <= st_idle;
                    frame_valid <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end else if (state != st_idle) begin
            // Device went quiet mid frame
            if (idle_cnt == IDLE_W'(`PS2_IDLE_TIMEOUT - 1)) begin
                state    <= st_idle;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            case (state)
                st_idle: parity_acc <= 1'b0;
                st_data: begin
                    shift_reg  <= {bit_value, shift_reg[7:1]};  // LSB first
                    parity_acc <= parity_acc ^ bit_value;
                end
                st_parity: parity_acc <= parity_acc ^ bit_value;
                st_stop: begin
                    frame.data       <= shift_reg;
                    frame.parity_err <= ~parity_acc;  // Odd parity expected
                    frame.stop_err   <= ~bit_value;
                end
                default: ;
            endcase
        end
    end

    // A frame only completes on the stop bit
    a_valid_after_stop : assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_valid |-> $past(bit_strobe && state == st_stop));

endmodule

`default_nettype wire

/* design/ps2_key_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ps2_cfg.svh"

module ps2_key_decoder
    import ps2_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        frame_valid,
    input  ps2_frame_t frame,
    output logic       key_valid,
    output key_event_t key_event,
    output logic       frame_error
);

    logic ext_flag;
    logic rel_flag;
    logic frame_bad;
    logic is_ext;
    logic is_break;

    assign frame_bad = frame.parity_err | frame.stop_err;
    assign is_ext    = frame.data == `PS2_EXT_PREFIX;
    assign is_break  = frame.data == `PS2_BREAK_PREFIX;

    // Prefix tracking and output pulses
    always_ff @(posedge clk) begin
        key_valid   <= 1'b0;
        frame_error <= 1'b0;
        if (!rst_n) begin
            ext_flag <= 1'b0;
            rel_flag <= 1'b0;
        end else if (frame_valid) begin
            if (frame_bad) begin
                frame_error <= 1'b1;
                ext_flag    <= 1'b0;  // Drop any pending prefix
                rel_flag    <= 1'b0;
            end else if (is_ext) begin
                ext_flag <= 1'b1;
            end else if (is_break) begin
                rel_flag <= 1'b1;
            end else begin
                key_valid <= 1'b1;
                ext_flag  <= 1'b0;
                rel_flag  <= 1'b0;
            end
        end
    end

    // Event payload loads only on a plain key
    always_ff @(posedge clk) begin
        if (frame_valid && !frame_bad && !is_ext && !is_break) begin
            key_event.code     <= frame.data;
            key_event.extended <= ext_flag;
            key_event.released <= rel_flag;
        end
    end

    // Each frame ends in at most one kind of output
    a_one_outcome : assert property (
        @(posedge clk) disable iff (!rst_n) !(key_valid && frame_error));

endmodule

`default_nettype wire

/* design/ps2_line_sync.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_line_sync (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  ps2_clk,
    input  wire  ps2_data,
    output logic bit_strobe,
    output logic bit_value
);

    logic clk_s1;
    logic clk_s2;
    logic clk_d;    // Previous synchronized clock level
    logic data_s1;
    logic data_s2;

    // Lines idle high, so reset to 1 to avoid a false edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_s1  <= 1'b1;
            clk_s2  <= 1'b1;
            clk_d   <= 1'b1;
            data_s1 <= 1'b1;
            data_s2 <= 1'b1;
        end else begin
            clk_s1  <= ps2_clk;
            clk_s2  <= clk_s1;
            clk_d   <= clk_s2;
            data_s1 <= ps2_data;
            data_s2 <= data_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= clk_d & ~clk_s2;  // Falling edge
        end
    end

    // Data is stable around the falling edge
    always_ff @(posedge clk) begin
        bit_value <= data_s2;
    end

    // Strobe must stay a single pulse per ps2_clk fall
    a_strobe_single : assert property (
        @(posedge clk) disable iff (!rst_n) bit_strobe |=> !bit_strobe);

endmodule

`default_nettype wire

/* design/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    typedef logic [7:0] scan_code_t;

    // One received frame with its status flags
    typedef struct packed {
        scan_code_t data;
        logic       parity_err;  // Ones over data and parity came out even
        logic       stop_err;    // Stop bit sampled low
    } ps2_frame_t;

    // Decoded key with its prefix flags
    typedef struct packed {
        scan_code_t code;
        logic       extended;    // E0 seen
        logic       released;    // F0 seen
    } key_event_t;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_parity,
        st_stop
    } frame_state_t;

endpackage

`default_nettype wire

/* design/ps2_rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2_rx_top
    import ps2_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    output logic       key_valid,
    output key_event_t key_event,
    output logic       frame_error
);

    logic       bit_strobe;
    logic       bit_value;
    logic       frame_valid;
    ps2_frame_t frame;

    ps2_line_sync u_line_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value)
    );

    ps2_frame_ctrl u_frame_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_strobe  (bit_strobe),
        .bit_value   (bit_value),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    ps2_key_decoder u_key_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame       (frame),
        .key_valid   (key_valid),
        .key_event   (key_event),
        .frame_error (frame_error)
    );

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/ps2_pkg.sv
design/ps2_line_sync.sv
design/ps2_frame_ctrl.sv
design/ps2_key_decoder.sv
design/ps2_rx_top.sv
verification/ps2_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PS/2 receiver testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module ps2_rx_tb -f files.f -o ps2_rx_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ps2_rx_sim > sim.log 2>&1
cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && exit 0 || exit 1

/* verification/ps2_rx_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ps2_cfg.svh"

module ps2_rx_tb
    import ps2_pkg::*;
();

    localparam int HALF         = 20;  // System clocks per ps2_clk half period
    localparam int IDLE_GAP     = 40;
    localparam int RESULT_WAIT  = 60;
    localparam int N_FIXED      = 14;
    localparam int N_RAND       = 16;
    localparam int N_ROWS       = N_FIXED + N_RAND;
    localparam int FRAME_CYCLES = 11 * (2 * HALF + 1) + RESULT_WAIT + IDLE_GAP;
    localparam int CYCLE_LIMIT  = N_ROWS * FRAME_CYCLES + `PS2_IDLE_TIMEOUT + 600;

    typedef enum logic [1:0] {
        exp_none,
        exp_key,
        exp_err
    } expect_t;

    typedef struct packed {
        scan_code_t data;
        logic       bad_parity;
        logic       bad_stop;
        logic       cut;        // Abandon after four data bits
        expect_t    outcome;
        key_event_t exp_event;
    } stim_row_t;

    // One output pulse as seen by the monitor
    typedef struct packed {
        logic       key_valid;
        logic       frame_error;
        key_event_t key_event;
    } seen_t;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       key_valid;
    key_event_t key_event;
    logic       frame_error;

    stim_row_t   rows [N_ROWS];
    seen_t       seen_q [$];
    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;

    ps2_rx_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_valid   (key_valid),
        .key_event   (key_event),
        .frame_error (frame_error)
    );

    always #5 clk = ~clk;

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && (key_valid || frame_error)) begin
            seen_q.push_back({key_valid, frame_error, key_event});
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_key_event(input key_event_t got, input key_event_t exp);
        if (got !== exp) begin
            $display("error at %0t: key_event got %h/%b/%b expected %h/%b/%b", $time,
                     got.code, got.extended, got.released,
                     exp.code, exp.extended, exp.released);
            fail_run();
        end
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    task automatic draw_byte(output scan_code_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b          = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic stim_row_t make_row(input scan_code_t data, input logic bad_parity,
                                           input logic bad_stop, input logic cut,
                                           input expect_t outcome, input logic ext,
                                           input logic rel);
        make_row = {data, bad_parity, bad_stop, cut, outcome, data, ext, rel};
    endfunction

    task automatic build_table();
        scan_code_t b;
        rows[0]  = make_row(8'h1C, 0, 0, 0, exp_key, 0, 0);
        rows[1]  = make_row(`PS2_BREAK_PREFIX, 0, 0, 0, exp_none, 0, 0);
        rows[2]  = make_row(8'h1C, 0, 0, 0, exp_key, 0, 1);
        rows[3]  = make_row(`PS2_EXT_PREFIX, 0, 0, 0, exp_none, 0, 0);
        rows[4]  = make_row(8'h75, 0, 0, 0, exp_key, 1, 0);
        rows[5]  = make_row(`PS2_EXT_PREFIX, 0, 0, 0, exp_none, 0, 0);
        rows[6]  = make_row(`PS2_BREAK_PREFIX, 0, 0, 0, exp_none, 0, 0);
        rows[7]  = make_row(8'h6B, 0, 0, 0, exp_key, 1, 1);
        rows[8]  = make_row(`PS2_EXT_PREFIX, 0, 0, 0, exp_none, 0, 0);
        rows[9]  = make_row(8'h5A, 1, 0, 0, exp_err, 0, 0);  // Also drops the E0
        rows[10] = make_row(8'h29, 0, 0, 0, exp_key, 0, 0);
        rows[11] = make_row(8'h33, 0, 1, 0, exp_err, 0, 0);
        rows[12] = make_row(8'h4D, 0, 0, 1, exp_none, 0, 0);
        rows[13] = make_row(8'h24, 0, 0, 0, exp_key, 0, 0);
        lfsr_state = 32'd81924;
        for (int i = 0; i < N_RAND; i++) begin
            draw_byte(b);
            while (b == `PS2_EXT_PREFIX || b == `PS2_BREAK_PREFIX) begin
                draw_byte(b);
            end
            rows[N_FIXED + i] = make_row(b, 0, 0, 0, exp_key, 0, 0);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Device model changes data only while ps2_clk is high
    task automatic send_bit(input logic b);
        @(posedge clk);
        ps2_data <= b;
        wait_clocks(HALF);
        ps2_clk <= 1'b0;
        wait_clocks(HALF);
        ps2_clk <= 1'b1;
    endtask

    task automatic send_frame(input stim_row_t r);
        logic [10:0] bits;
        int          n;
        bits = {~r.bad_stop, (~^r.data) ^ r.bad_parity, r.data, 1'b0};
        n    = r.cut ? 5 : 11;
        for (int i = 0; i < n; i++) begin
            send_bit(bits[i]);
        end
        @(posedge clk);
        ps2_data <= 1'b1;
    endtask

    task automatic await_output();
        int waited;
        waited = 0;
        while (seen_q.size() == 0 && waited < RESULT_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (seen_q.size() == 0) begin
            $display("No output arrived within %0d clocks after the stop bit", RESULT_WAIT);
            fail_run();
        end
    endtask

    task automatic verify_row(input int idx, input stim_row_t r);
        seen_t s;
        if (r.outcome != exp_none) begin
            s = seen_q.pop_front();
            check_bit("key_valid", s.key_valid, r.outcome == exp_key);
            check_bit("frame_error", s.frame_error, r.outcome == exp_err);
            if (r.outcome == exp_key) begin
                check_key_event(s.key_event, r.exp_event);
            end
        end
        if (seen_q.size() != 0) begin
            $display("Row %0d (byte %h) produced an output that was not expected", idx, r.data);
            fail_run();
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        build_table();
        wait_clocks(2);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("key_valid", key_valid, 1'b0);
        check_bit("frame_error", frame_error, 1'b0);
        for (int i = 0; i < N_ROWS; i++) begin
            send_frame(rows[i]);
            if (rows[i].outcome != exp_none) begin
                await_output();
            end
            if (rows[i].cut) begin
                wait_clocks(`PS2_IDLE_TIMEOUT + 100);  // Let the frame timeout fire
            end else begin
                wait_clocks(IDLE_GAP);
            end
            verify_row(i, rows[i]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
